/* include/tracker_consts.svh */
// ====================================================================
// Object tracker constants
// Brightness threshold, frame counts, servo timing and home aim point
// ====================================================================

`ifndef TRACKER_CONSTS_SVH
`define TRACKER_CONSTS_SVH

// Pixel at or above this level belongs to the object
`define TRK_THRESHOLD      12'h800

// Fewest bright pixels for a usable centroid
`define TRK_MIN_PIXELS     4

// Frames ending without a centroid before the target is lost
`define TRK_MISS_FRAMES    2

// Consecutive centroids before firing
`define TRK_LOCK_FRAMES    3

// Servo PWM period and pulse width at coordinate zero
`define TRK_SERVO_PERIOD   1024
`define TRK_PAN_BASE       64
`define TRK_TILT_BASE      64

// Aim point with no target
`define TRK_HOME_X         320
`define TRK_HOME_Y         240

`endif

/* design/tracker_pkg.sv */
// ====================================================================
// Object tracker types
// Pixel, coordinate, accumulator and servo widths, aim FSM states
// ====================================================================

package tracker_pkg;

    // Raw sensor sample
    typedef logic [11:0] pixel_t;

    // Column and row indices
    typedef logic [9:0]  coord_x_t;
    typedef logic [8:0]  coord_y_t;

    // Per-frame accumulators
    typedef logic [31:0] sum_t;
    typedef logic [19:0] count_t;

    typedef logic [15:0] frame_count_t;

    // Servo pulse width in clock cycles
    typedef logic [10:0] pulse_t;

    typedef enum logic [1:0] {
        SEARCH,
        TRACK,
        FIRE
    } aim_state_t;

endpackage

/* design/ccd_capture.sv */
// ====================================================================
// Sensor capture
// Registers the D5M pins, arms on frame boundaries and counts
// columns, rows and captured frames
// ====================================================================

`timescale 1ns/1ps

module ccd_capture (
    input  logic                      D5M_PIXLCLK,
    input  logic                      reset,
    input  tracker_pkg::pixel_t       D5M_D,
    input  logic                      D5M_FVAL,
    input  logic                      D5M_LVAL,
    input  logic                      arm_start,
    input  logic                      arm_stop,
    output tracker_pkg::pixel_t       pixel,
    output logic                      pixel_valid,
    output tracker_pkg::coord_x_t     x_pos,
    output tracker_pkg::coord_y_t     y_pos,
    output logic                      frame_end,
    output tracker_pkg::frame_count_t frame_count
);

    import tracker_pkg::*;

    pixel_t d_reg;
    logic   fval_reg;
    logic   lval_reg;
    logic   fval_d;
    logic   lval_d;
    logic   run;
    logic   capturing;
    logic   fval_rise;
    logic   fval_fall;
    logic   capture_now;

    assign fval_rise = fval_reg && !fval_d;
    assign fval_fall = !fval_reg && fval_d;

    // Arm state changes only as a frame opens
    assign capture_now = fval_rise ? run : capturing;

    always_ff @(posedge D5M_PIXLCLK)
    begin
        d_reg <= D5M_D;
        pixel <= d_reg;
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            fval_reg    <= 1'b0;
            lval_reg    <= 1'b0;
            fval_d      <= 1'b0;
            lval_d      <= 1'b0;
            run         <= 1'b0;
            capturing   <= 1'b0;
            pixel_valid <= 1'b0;
            x_pos       <= '0;
            y_pos       <= '0;
            frame_end   <= 1'b0;
            frame_count <= '0;
        end
        else
        begin
            fval_reg <= D5M_FVAL;
            lval_reg <= D5M_LVAL;
            fval_d   <= fval_reg;
            lval_d   <= lval_reg;

            if (arm_start)
                run <= 1'b1;
            else if (arm_stop)
                run <= 1'b0;

            if (fval_rise)
                capturing <= run;

            pixel_valid <= capture_now && fval_reg && lval_reg;

            // Column restarts on the first pixel of each line
            if (fval_reg && lval_reg)
                x_pos <= lval_d ? x_pos + 1'b1 : '0;

            if (!fval_reg)
                y_pos <= '0;
            else if (lval_d && !lval_reg)
                y_pos <= y_pos + 1'b1;

            frame_end <= fval_fall && capturing;
            if (fval_fall && capturing)
                frame_count <= frame_count + 1'b1;
        end
    end

    a_valid_in_line: assert property (@(posedge D5M_PIXLCLK) disable iff (reset)
        pixel_valid |-> (lval_d && fval_d))
        else $error("pixel_valid outside an active line");

endmodule

/* design/coord_divider.sv */
// ====================================================================
// Coordinate divider
// Restoring divider, one quotient bit per cycle, for sum / count
// ====================================================================

`timescale 1ns/1ps

module coord_divider #(
    parameter int QUOTIENT_BITS = 10
) (
    input  logic                     D5M_PIXLCLK,
    input  logic                     reset,
    input  logic                     start,
    input  tracker_pkg::sum_t        dividend,
    input  tracker_pkg::count_t      divisor,
    output logic [QUOTIENT_BITS-1:0] quotient,
    output logic                     done
);

    import tracker_pkg::*;

    localparam int STEP_W = $clog2(QUOTIENT_BITS + 1);

    sum_t              rem;
    sum_t              den;
    sum_t              cur_rem;
    sum_t              cur_den;
    logic [STEP_W-1:0] steps_left;
    logic              busy;
    logic              ge;

    // First bit is resolved in the start cycle itself
    assign cur_rem = start ? dividend : rem;
    assign cur_den = start ? (sum_t'(divisor) << (QUOTIENT_BITS - 1)) : den;
    assign ge      = cur_rem >= cur_den;

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            steps_left <= '0;
            done       <= 1'b0;
        end
        else
        begin
            done <= busy && (steps_left == STEP_W'(1));
            if (start)
            begin
                busy       <= 1'b1;
                steps_left <= STEP_W'(QUOTIENT_BITS - 1);
            end
            else if (busy)
            begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == STEP_W'(1))
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (start || busy)
        begin
            rem      <= ge ? cur_rem - cur_den : cur_rem;
            den      <= cur_den >> 1;
            quotient <= {quotient[QUOTIENT_BITS-2:0], ge};
        end
    end

    a_no_overlap: assert property (@(posedge D5M_PIXLCLK) disable iff (reset)
        start |-> !busy)
        else $error("divider started while busy");

endmodule

/* design/centroid_accumulator.sv */
// ====================================================================
// Centroid accumulator
// Sums the coordinates of bright pixels over a frame and divides
// by the pixel count to get the mean column and row
// ====================================================================

`timescale 1ns/1ps
`include "tracker_consts.svh"

module centroid_accumulator (
    input  logic                  D5M_PIXLCLK,
    input  logic                  reset,
    input  tracker_pkg::pixel_t   pixel,
    input  logic                  pixel_valid,
    input  tracker_pkg::coord_x_t x_pos,
    input  tracker_pkg::coord_y_t y_pos,
    input  logic                  frame_end,
    output tracker_pkg::coord_x_t centroid_x,
    output tracker_pkg::coord_y_t centroid_y,
    output logic                  centroid_valid
);

    import tracker_pkg::*;

    sum_t     sum_x;
    sum_t     sum_y;
    count_t   count;
    sum_t     snap_x;
    sum_t     snap_y;
    count_t   snap_count;
    logic     bright;
    logic     div_start;
    logic     x_done;
    logic     y_done;
    logic     y_ready;
    coord_x_t quot_x;
    coord_y_t quot_y;

    assign bright = pixel_valid && (pixel >= pixel_t'(`TRK_THRESHOLD));

    // ================================================================
    // Per-frame accumulation
    // ================================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            sum_x     <= '0;
            sum_y     <= '0;
            count     <= '0;
            div_start <= 1'b0;
        end
        else
        begin
            div_start <= frame_end && (count >= count_t'(`TRK_MIN_PIXELS));
            if (frame_end)
            begin
                sum_x <= '0;
                sum_y <= '0;
                count <= '0;
            end
            else if (bright)
            begin
                sum_x <= sum_x + sum_t'(x_pos);
                sum_y <= sum_y + sum_t'(y_pos);
                count <= count + 1'b1;
            end
        end
    end

    // Frame totals held for the dividers
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (frame_end)
        begin
            snap_x     <= sum_x;
            snap_y     <= sum_y;
            snap_count <= count;
        end
    end

    // ================================================================
    // Mean column and row
    // ================================================================
    coord_divider #(.QUOTIENT_BITS($bits(coord_x_t))) i_div_x (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .reset       (reset),
        .start       (div_start),
        .dividend    (snap_x),
        .divisor     (snap_count),
        .quotient    (quot_x),
        .done        (x_done)
    );

    coord_divider #(.QUOTIENT_BITS($bits(coord_y_t))) i_div_y (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .reset       (reset),
        .start       (div_start),
        .dividend    (snap_y),
        .divisor     (snap_count),
        .quotient    (quot_y),
        .done        (y_done)
    );

    // Row divider is shorter, so its result waits for the column
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            y_ready        <= 1'b0;
            centroid_valid <= 1'b0;
        end
        else
        begin
            if (div_start)
                y_ready <= 1'b0;
            else if (y_done)
                y_ready <= 1'b1;
            centroid_valid <= x_done && (y_ready || y_done);
        end
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (x_done)
        begin
            centroid_x <= quot_x;
            centroid_y <= quot_y;
        end
    end

endmodule

/* design/target_hold.sv */
// ====================================================================
// Target hold
// Keeps the last centroid and drops on_screen after missed frames
// ====================================================================

`timescale 1ns/1ps
`include "tracker_consts.svh"

module target_hold (
    input  logic                  D5M_PIXLCLK,
    input  logic                  reset,
    input  tracker_pkg::coord_x_t centroid_x,
    input  tracker_pkg::coord_y_t centroid_y,
    input  logic                  centroid_valid,
    input  logic                  frame_end,
    output tracker_pkg::coord_x_t target_x,
    output tracker_pkg::coord_y_t target_y,
    output logic                  on_screen
);

    logic [3:0] miss_cnt;

    // Every frame end counts a miss until its centroid clears it
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            on_screen <= 1'b0;
            miss_cnt  <= '0;
        end
        else if (centroid_valid)
        begin
            on_screen <= 1'b1;
            miss_cnt  <= '0;
        end
        else if (frame_end)
        begin
            if (miss_cnt < 4'(`TRK_MISS_FRAMES))
                miss_cnt <= miss_cnt + 1'b1;
            if (miss_cnt >= 4'(`TRK_MISS_FRAMES - 1))
                on_screen <= 1'b0;
        end
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (centroid_valid)
        begin
            target_x <= centroid_x;
            target_y <= centroid_y;
        end
    end

endmodule

/* design/aim_control.sv */
// ====================================================================
// Aim control
// Search, track and fire FSM, servo pulse widths from the aim point
// ====================================================================

`timescale 1ns/1ps
`include "tracker_consts.svh"

module aim_control (
    input  logic                  D5M_PIXLCLK,
    input  logic                  reset,
    input  tracker_pkg::coord_x_t target_x,
    input  tracker_pkg::coord_y_t target_y,
    input  logic                  on_screen,
    input  logic                  centroid_valid,
    input  logic                  frame_end,
    output tracker_pkg::pulse_t   pan_width,
    output tracker_pkg::pulse_t   tilt_width,
    output logic                  fire
);

    import tracker_pkg::*;

    aim_state_t state;
    aim_state_t state_next;
    logic [3:0] lock_cnt;
    logic       seen;
    coord_x_t   aim_x;
    coord_y_t   aim_y;

    always_comb
    begin
        state_next = state;
        case (state)
            SEARCH:
                if (on_screen)
                    state_next = TRACK;
            TRACK:
                if (!on_screen)
                    state_next = SEARCH;
                else if (lock_cnt >= 4'(`TRK_LOCK_FRAMES))
                    state_next = FIRE;
            FIRE:
                if (!on_screen)
                    state_next = SEARCH;
            default:
                state_next = SEARCH;
        endcase
    end

    assign aim_x = (state_next == SEARCH) ? coord_x_t'(`TRK_HOME_X) : target_x;
    assign aim_y = (state_next == SEARCH) ? coord_y_t'(`TRK_HOME_Y) : target_y;

    // Fire drops in the same cycle as on_screen
    assign fire  = (state_next == FIRE);

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            state      <= SEARCH;
            lock_cnt   <= '0;
            seen       <= 1'b0;
            pan_width  <= pulse_t'(`TRK_PAN_BASE + `TRK_HOME_X);
            tilt_width <= pulse_t'(`TRK_TILT_BASE + `TRK_HOME_Y);
        end
        else
        begin
            state <= state_next;

            // A frame end with no centroid since the last one breaks the lock
            if (frame_end)
            begin
                seen <= 1'b0;
                if (!seen)
                    lock_cnt <= '0;
            end
            else if (centroid_valid)
            begin
                seen <= 1'b1;
                if (lock_cnt < 4'(`TRK_LOCK_FRAMES))
                    lock_cnt <= lock_cnt + 1'b1;
            end

            pan_width  <= pulse_t'(`TRK_PAN_BASE) + pulse_t'(aim_x);
            tilt_width <= pulse_t'(`TRK_TILT_BASE) + pulse_t'(aim_y);
        end
    end

    a_fire_on_target: assert property (@(posedge D5M_PIXLCLK) disable iff (reset)
        fire |-> on_screen)
        else $error("fire without a target on screen");

endmodule

/* design/servo_pwm.sv */
// ====================================================================
// Servo PWM
// Fixed period, pulse width sampled at the start of each period
// ====================================================================

`timescale 1ns/1ps
`include "tracker_consts.svh"

module servo_pwm (
    input  logic                D5M_PIXLCLK,
    input  logic                reset,
    input  tracker_pkg::pulse_t width,
    output logic                pwm
);

    import tracker_pkg::*;

    localparam int PERIOD = `TRK_SERVO_PERIOD;
    localparam int CNT_W  = $clog2(PERIOD);

    logic [CNT_W-1:0] period_cnt;
    pulse_t           width_q;

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            period_cnt <= '0;
            width_q    <= '0;
        end
        else if (period_cnt == CNT_W'(PERIOD - 1))
        begin
            period_cnt <= '0;
            width_q    <= width;
        end
        else
            period_cnt <= period_cnt + 1'b1;
    end

    // High for width_q cycles from the period start
    assign pwm = pulse_t'(period_cnt) < width_q;

endmodule

/* design/object_tracker_top.sv */
// ====================================================================
// Object tracker top level
// Capture, centroid, target hold, aim FSM and two servo outputs
// ====================================================================

`timescale 1ns/1ps

module object_tracker_top (
    input  logic                      D5M_PIXLCLK,
    input  logic                      reset,
    input  tracker_pkg::pixel_t       D5M_D,
    input  logic                      D5M_FVAL,
    input  logic                      D5M_LVAL,
    input  logic                      arm_start,
    input  logic                      arm_stop,
    output tracker_pkg::frame_count_t frame_count,
    output tracker_pkg::coord_x_t     centroid_x,
    output tracker_pkg::coord_y_t     centroid_y,
    output logic                      centroid_valid,
    output logic                      on_screen,
    output logic                      fire,
    output logic                      pan_pwm,
    output logic                      tilt_pwm
);

    import tracker_pkg::*;

    pixel_t   pixel;
    logic     pixel_valid;
    coord_x_t x_pos;
    coord_y_t y_pos;
    logic     frame_end;
    coord_x_t target_x;
    coord_y_t target_y;
    pulse_t   pan_width;
    pulse_t   tilt_width;

    ccd_capture i_capture (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .reset       (reset),
        .D5M_D       (D5M_D),
        .D5M_FVAL    (D5M_FVAL),
        .D5M_LVAL    (D5M_LVAL),
        .arm_start   (arm_start),
        .arm_stop    (arm_stop),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .x_pos       (x_pos),
        .y_pos       (y_pos),
        .frame_end   (frame_end),
        .frame_count (frame_count)
    );

    centroid_accumulator i_centroid (
        .D5M_PIXLCLK    (D5M_PIXLCLK),
        .reset          (reset),
        .pixel          (pixel),
        .pixel_valid    (pixel_valid),
        .x_pos          (x_pos),
        .y_pos          (y_pos),
        .frame_end      (frame_end),
        .centroid_x     (centroid_x),
        .centroid_y     (centroid_y),
        .centroid_valid (centroid_valid)
    );

    target_hold i_hold (
        .D5M_PIXLCLK    (D5M_PIXLCLK),
        .reset          (reset),
        .centroid_x     (centroid_x),
        .centroid_y     (centroid_y),
        .centroid_valid (centroid_valid),
        .frame_end      (frame_end),
        .target_x       (target_x),
        .target_y       (target_y),
        .on_screen      (on_screen)
    );

    aim_control i_aim (
        .D5M_PIXLCLK    (D5M_PIXLCLK),
        .reset          (reset),
        .target_x       (target_x),
        .target_y       (target_y),
        .on_screen      (on_screen),
        .centroid_valid (centroid_valid),
        .frame_end      (frame_end),
        .pan_width      (pan_width),
        .tilt_width     (tilt_width),
        .fire           (fire)
    );

    servo_pwm pan_servo (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .reset       (reset),
        .width       (pan_width),
        .pwm         (pan_pwm)
    );

    servo_pwm tilt_servo (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .reset       (reset),
        .width       (tilt_width),
        .pwm         (tilt_pwm)
    );

endmodule

/* sim/tb_object_tracker.sv */
// ====================================================================
// Object tracker testbench
// Plays frames from the input file and checks centroid, frame count,
// target hold, fire and both servo pulse widths
// ====================================================================

`timescale 1ns/1ps
`include "tracker_consts.svh"

module tb_object_tracker;

    import tracker_pkg::*;

    localparam int MEM_WORDS       = 512;
    localparam int HDR_WORDS       = 5;
    localparam int CENTROID_WINDOW = 40;
    localparam int PWM_LIMIT       = 2 * `TRK_SERVO_PERIOD + 16;

    logic         D5M_PIXLCLK;
    logic         reset;
    pixel_t       D5M_D;
    logic         D5M_FVAL;
    logic         D5M_LVAL;
    logic         arm_start;
    logic         arm_stop;
    frame_count_t frame_count;
    coord_x_t     centroid_x;
    coord_y_t     centroid_y;
    logic         centroid_valid;
    logic         on_screen;
    logic         fire;
    logic         pan_pwm;
    logic         tilt_pwm;

    logic [15:0]  stim [0:MEM_WORDS-1];
    integer       seed;
    int           rd_ptr;
    coord_x_t     exp_x;
    coord_y_t     exp_y;
    logic         exp_valid;

    object_tracker_top i_dut (
        .D5M_PIXLCLK    (D5M_PIXLCLK),
        .reset          (reset),
        .D5M_D          (D5M_D),
        .D5M_FVAL       (D5M_FVAL),
        .D5M_LVAL       (D5M_LVAL),
        .arm_start      (arm_start),
        .arm_stop       (arm_stop),
        .frame_count    (frame_count),
        .centroid_x     (centroid_x),
        .centroid_y     (centroid_y),
        .centroid_valid (centroid_valid),
        .on_screen      (on_screen),
        .fire           (fire),
        .pan_pwm        (pan_pwm),
        .tilt_pwm       (tilt_pwm)
    );

    always #100 D5M_PIXLCLK = ~D5M_PIXLCLK;

    // ================================================================
    // Helpers
    // ================================================================

    // Inputs change and outputs are sampled 1 ns past the edge
    task automatic next_cycle();
        @(posedge D5M_PIXLCLK);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    // Frame header, then width x height pixels, random line blanking
    task automatic drive_frame();
        int width;
        int height;
        int row;
        int col;
        int gap;
        width     = int'(stim[rd_ptr]);
        height    = int'(stim[rd_ptr + 1]);
        exp_x     = coord_x_t'(stim[rd_ptr + 2]);
        exp_y     = coord_y_t'(stim[rd_ptr + 3]);
        exp_valid = stim[rd_ptr + 4][0];
        rd_ptr    = rd_ptr + HDR_WORDS;
        D5M_FVAL  = 1'b1;
        next_cycle();
        for (row = 0; row < height; row++)
        begin
            D5M_LVAL = 1'b1;
            for (col = 0; col < width; col++)
            begin
                D5M_D  = pixel_t'(stim[rd_ptr]);
                rd_ptr = rd_ptr + 1;
                next_cycle();
            end
            D5M_LVAL = 1'b0;
            D5M_D    = '0;
            gap = 2 + int'($unsigned($random(seed)) % 4);
            repeat (gap) next_cycle();
        end
        D5M_FVAL = 1'b0;
    endtask

    // Watch the frame end for a centroid pulse
    task automatic finish_frame(input string name);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < CENTROID_WINDOW)
        begin
            next_cycle();
            waited++;
            if (centroid_valid)
            begin
                seen = 1'b1;
                check({name, " centroid_x"}, 32'(exp_x), 32'(centroid_x));
                check({name, " centroid_y"}, 32'(exp_y), 32'(centroid_y));
            end
        end
        if (exp_valid && !seen)
            abort_run({"Timed out waiting for centroid_valid on ", name});
        else
            check({name, " centroid_valid"}, 32'(exp_valid), 32'(seen));
        // Hold and aim registers follow the centroid
        repeat (4) next_cycle();
    endtask

    // High time of both servos over one full period
    task automatic measure_servos(output int pan_cycles, output int tilt_cycles);
        int waited;
        waited = 0;
        while (pan_pwm && waited < PWM_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (pan_pwm)
            abort_run("Timed out waiting for pan_pwm to go low");
        waited = 0;
        while (!pan_pwm && waited < PWM_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!pan_pwm)
            abort_run("Timed out waiting for a pan_pwm period start");
        pan_cycles  = 0;
        tilt_cycles = 0;
        waited      = 0;
        while ((pan_pwm || tilt_pwm) && waited < PWM_LIMIT)
        begin
            if (pan_pwm)
                pan_cycles++;
            if (tilt_pwm)
                tilt_cycles++;
            next_cycle();
            waited++;
        end
        if (pan_pwm || tilt_pwm)
            abort_run("Timed out waiting for the servo pulses to end");
    endtask

    // ================================================================
    // Test sequence
    // ================================================================
    initial
    begin
        string    name;
        int       frame;
        int       pan_high;
        int       tilt_high;
        int       lock_run;
        int       misses;
        logic     exp_on;
        logic     exp_fire;
        coord_x_t held_x;
        coord_y_t held_y;

        D5M_PIXLCLK = 1'b0;
        reset       = 1'b1;
        D5M_D       = '0;
        D5M_FVAL    = 1'b0;
        D5M_LVAL    = 1'b0;
        arm_start   = 1'b0;
        arm_stop    = 1'b0;
        seed        = 32'hae8fce95;
        rd_ptr      = 0;
        lock_run    = 0;
        misses      = 0;
        exp_on      = 1'b0;
        exp_fire    = 1'b0;
        held_x      = coord_x_t'(`TRK_HOME_X);
        held_y      = coord_y_t'(`TRK_HOME_Y);
        $readmemh("sim/tracker_input.txt", stim);

        repeat (2) next_cycle();
        reset = 1'b0;
        check("reset centroid_valid", 0, 32'(centroid_valid));
        check("reset on_screen", 0, 32'(on_screen));
        check("reset fire", 0, 32'(fire));
        check("reset pan_pwm", 0, 32'(pan_pwm));
        check("reset tilt_pwm", 0, 32'(tilt_pwm));
        check("reset frame_count", 0, 32'(frame_count));

        measure_servos(pan_high, tilt_high);
        check("home pan width", `TRK_PAN_BASE + `TRK_HOME_X, 32'(pan_high));
        check("home tilt width", `TRK_TILT_BASE + `TRK_HOME_Y, 32'(tilt_high));

        // Frame before arming is ignored
        drive_frame();
        finish_frame("frame 0");
        check("frame 0 frame_count", 0, 32'(frame_count));

        arm_start = 1'b1;
        next_cycle();
        arm_start = 1'b0;

        for (frame = 1; frame <= 5; frame++)
        begin
            name = $sformatf("frame %0d", frame);
            drive_frame();
            finish_frame(name);
            check({name, " frame_count"}, 32'(frame), 32'(frame_count));

            if (exp_valid)
            begin
                held_x   = exp_x;
                held_y   = exp_y;
                lock_run = lock_run + 1;
                misses   = 0;
                exp_on   = 1'b1;
            end
            else
            begin
                lock_run = 0;
                misses   = misses + 1;
                if (misses >= `TRK_MISS_FRAMES)
                    exp_on = 1'b0;
            end
            // Fire latches on a steady lock and drops with the target
            exp_fire = exp_on && (exp_fire || lock_run >= `TRK_LOCK_FRAMES);
            check({name, " on_screen"}, 32'(exp_on), 32'(on_screen));
            check({name, " fire"}, 32'(exp_fire), 32'(fire));

            measure_servos(pan_high, tilt_high);
            if (exp_on)
            begin
                check({name, " pan width"}, `TRK_PAN_BASE + 32'(held_x), 32'(pan_high));
                check({name, " tilt width"}, `TRK_TILT_BASE + 32'(held_y), 32'(tilt_high));
            end
            else
            begin
                check({name, " pan width"}, `TRK_PAN_BASE + `TRK_HOME_X, 32'(pan_high));
                check({name, " tilt width"}, `TRK_TILT_BASE + `TRK_HOME_Y, 32'(tilt_high));
            end
        end

        // Disarmed, so the next frame is not counted
        arm_stop = 1'b1;
        next_cycle();
        arm_stop = 1'b0;
        drive_frame();
        finish_frame("frame 6");
        check("frame 6 frame_count", 5, 32'(frame_count));

        $display("All tests passed");
        $finish;
    end

endmodule

/* sim/tracker_input.txt */
// Per frame a header: width height expected_x expected_y flag (hex),
// then one line of hex pixels per row; flag 1 means a centroid is expected
// Frame 0, sent before arming
6 4 0 0 0
000 000 000 000 000 000
000 fff fff 000 000 000
000 fff fff 000 000 000
000 000 000 000 000 000
// Frame 1, threshold edge, the 7ff pixel stays out
6 4 2 1 1
000 000 000 000 000 000
000 000 800 fff 000 000
000 000 900 a00 000 000
000 000 000 000 000 7ff
// Frame 2
6 4 3 2 1
000 000 000 000 000 000
000 000 000 000 000 000
000 000 000 c00 c00 000
000 000 000 c00 c00 c00
// Frame 3, spread out blob
6 4 3 1 1
000 fff 000 000 000 fff
000 000 000 000 000 000
000 000 000 fff 000 000
000 fff 000 000 000 fff
// Frame 4, three bright pixels only
6 4 0 0 0
fff fff 000 000 000 000
fff 000 000 000 000 000
000 000 000 7ff 000 000
000 000 000 000 000 000
// Frame 5, nothing at threshold
6 4 0 0 0
000 000 000 000 000 000
000 000 7ff 7ff 000 000
000 000 7ff 7ff 000 000
000 000 000 000 000 000
// Frame 6, sent after disarming
6 4 0 0 0
000 000 000 000 fff fff
000 000 000 000 fff fff
000 000 000 000 000 000
000 000 000 000 000 000

/* sim.f */
+incdir+include
design/tracker_pkg.sv
design/ccd_capture.sv
design/coord_divider.sv
design/centroid_accumulator.sv
design/target_hold.sv
design/aim_control.sv
design/servo_pwm.sv
design/object_tracker_top.sv
sim/tb_object_tracker.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_object_tracker
FILELIST  := sim.f
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
